//--- hdl/bus_arbiter.sv
`default_nettype none

module bus_arbiter (
	input  wire                            gbclk,
	input  wire                            arst_n,
	input  wire  [gb_bus_pkg::adr_w-1:0]   paddr,
	input  wire                            psel,
	input  wire                            penable,
	input  wire                            pwrite,
	input  wire  [gb_bus_pkg::data_w-1:0]  pwdata,
	output logic [gb_bus_pkg::data_w-1:0]  prdata,
	output logic                           pready,
	input  wire gb_bus_pkg::region_t       cpu_region,
	input  wire gb_bus_pkg::region_t       dma_region,
	input  wire                            dma_active,
	input  wire  [gb_bus_pkg::adr_w-1:0]   dma_src_adr,
	input  wire                            dma_src_rd,
	input  wire  [gb_bus_pkg::oam_aw-1:0]  dma_oam_idx,
	input  wire                            dma_oam_wr,
	input  wire  [gb_bus_pkg::data_w-1:0]  dma_oam_wdata,
	input  wire  [gb_bus_pkg::data_w-1:0]  dma_reg_q,
	output logic                           dma_reg_wr,
	output logic [gb_bus_pkg::data_w-1:0]  dma_src_rdata,
	output logic [gb_bus_pkg::vram_aw-1:0] vram_adr,
	output logic [gb_bus_pkg::data_w-1:0]  vram_wdata,
	output logic                           vram_we,
	input  wire  [gb_bus_pkg::data_w-1:0]  vram_rdata,
	output logic [gb_bus_pkg::oam_aw-1:0]  oam_adr,
	output logic [gb_bus_pkg::data_w-1:0]  oam_wdata,
	output logic                           oam_we,
	input  wire  [gb_bus_pkg::data_w-1:0]  oam_rdata,
	output logic [gb_bus_pkg::hram_aw-1:0] hram_adr,
	output logic [gb_bus_pkg::data_w-1:0]  hram_wdata,
	output logic                           hram_we,
	input  wire  [gb_bus_pkg::data_w-1:0]  hram_rdata,
	output logic [gb_bus_pkg::adr_w-1:0]   ext_req_adr,
	output logic                           ext_req_rd,
	output logic                           ext_req_wr,
	output logic [gb_bus_pkg::data_w-1:0]  ext_req_wdata,
	output gb_bus_pkg::region_t            ext_req_region,
	input  wire  [gb_bus_pkg::data_w-1:0]  ext_rdata
);

	logic                          ready_q;   // target was ours last access cycle.
	logic [gb_bus_pkg::data_w-1:0] ext_rdata_q;
	logic                          cpu_ext;
	logic                          dma_ext;
	logic                          dma_ext_rd;
	logic                          blocked;
	logic                          cpu_wr;

	assign cpu_ext    = cpu_region.rom | cpu_region.cram | cpu_region.wram;
	assign dma_ext    = dma_region.rom | dma_region.cram | dma_region.wram;
	assign dma_ext_rd = dma_src_rd & dma_ext;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// apb access phase, one wait state, dma stall
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign blocked = dma_active & (cpu_region.oam | (cpu_ext & dma_ext)
			| (cpu_region.vram & dma_region.vram));

	assign pready = psel & penable & ready_q & ~blocked;
	assign cpu_wr = pready & pwrite;   // writes land on the completing edge.

	always_ff @(posedge gbclk or negedge arst_n) begin
		if (!arst_n) begin
			ready_q <= 1'b0;
		end else begin
			ready_q <= psel & penable & ~blocked & ~pready;
		end
	end

	// external memory answers combinationally; sampled to line up with the rams.
	always_ff @(posedge gbclk) begin
		ext_rdata_q <= ext_rdata;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// port steering, dma first
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		if (dma_ext_rd) begin
			ext_req_adr    = dma_src_adr;
			ext_req_region = dma_region;
			ext_req_rd     = 1'b1;
			ext_req_wr     = 1'b0;
		end else begin
			ext_req_adr    = paddr;
			ext_req_region = cpu_region;
			ext_req_rd     = psel & penable & ~pwrite & cpu_ext;
			ext_req_wr     = cpu_wr & cpu_ext;
		end
	end

	always_comb begin
		if (dma_src_rd && dma_region.vram) begin
			vram_adr = dma_src_adr[gb_bus_pkg::vram_aw-1:0];
			vram_we  = 1'b0;
		end else begin
			vram_adr = paddr[gb_bus_pkg::vram_aw-1:0];
			vram_we  = cpu_wr & cpu_region.vram;
		end
	end

	always_comb begin
		if (dma_active) begin   // oam belongs to the dma for the whole copy.
			oam_adr   = dma_oam_idx;
			oam_we    = dma_oam_wr;
			oam_wdata = dma_oam_wdata;
		end else begin
			oam_adr   = paddr[gb_bus_pkg::oam_aw-1:0];
			oam_we    = cpu_wr & cpu_region.oam;
			oam_wdata = pwdata;
		end
	end

	assign hram_adr      = paddr[gb_bus_pkg::hram_aw-1:0];
	assign hram_we       = cpu_wr & cpu_region.hram;
	assign hram_wdata    = pwdata;
	assign vram_wdata    = pwdata;
	assign ext_req_wdata = pwdata;
	assign dma_reg_wr    = cpu_wr & cpu_region.io_dma;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// read data
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		case (1'b1)
			cpu_ext:           prdata = ext_rdata_q;
			cpu_region.vram:   prdata = vram_rdata;
			cpu_region.oam:    prdata = oam_rdata;
			cpu_region.hram:   prdata = hram_rdata;
			cpu_region.io_dma: prdata = dma_reg_q;
			default:           prdata = gb_bus_pkg::open_bus;
		endcase
	end

	always_comb begin
		if (dma_region.vram) begin
			dma_src_rdata = vram_rdata;
		end else if (dma_ext) begin
			dma_src_rdata = ext_rdata_q;
		end else begin
			dma_src_rdata = gb_bus_pkg::open_bus;   // oam or io page as source.
		end
	end

endmodule

`default_nettype wire

//--- hdl/cart_mapper.sv
`default_nettype none

module cart_mapper (
	input  wire                           gbclk,
	input  wire                           arst_n,
	input  wire                           emu_mbc,
	input  wire  [gb_bus_pkg::adr_w-1:0]  req_adr,
	input  wire                           req_rd,
	input  wire                           req_wr,
	input  wire  [gb_bus_pkg::data_w-1:0] req_wdata,
	input  wire gb_bus_pkg::region_t      req_region,
	output gb_bus_pkg::ext_bus_t          ext
);

	logic [gb_bus_pkg::rom_bank_bits-1:0] rom_bank;
	logic [gb_bus_pkg::ram_bank_bits-1:0] ram_bank;
	logic                                 ram_en;
	logic                                 req;
	logic                                 mbc_wr;

	assign req    = req_rd | req_wr;
	assign mbc_wr = emu_mbc & req_wr & req_region.rom;   // rom writes hit registers.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// bank registers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge gbclk or negedge arst_n) begin
		if (!arst_n) begin
			rom_bank <= gb_bus_pkg::rom_bank_bits'(1);
			ram_bank <= '0;
			ram_en   <= 1'b0;
		end else if (mbc_wr) begin
			case (req_adr[14:13])
				2'd0: ram_en <= (req_wdata[3:0] == 4'hA);
				2'd1: begin
					if (req_wdata[gb_bus_pkg::rom_bank_bits-1:0] == '0) begin
						rom_bank <= gb_bus_pkg::rom_bank_bits'(1);   // bank 0 not selectable.
					end else begin
						rom_bank <= req_wdata[gb_bus_pkg::rom_bank_bits-1:0];
					end
				end
				2'd2: ram_bank <= req_wdata[gb_bus_pkg::ram_bank_bits-1:0];
				default: ;
			endcase
		end
	end

	always_comb begin
		ext       = '0;
		ext.wdata = req_wdata;

		if (req_region.wram) begin
			// echo folds onto c000-dfff.
			ext.adr.rom.bank = gb_bus_pkg::rom_bank_bits'(req_adr[15:14]);
			ext.adr.rom.ofs  = {1'b0, req_adr[12:0]};
			ext.cs_ram       = req;
		end else if (req_region.rom | req_region.cram) begin
			ext.adr.rom.bank = gb_bus_pkg::rom_bank_bits'(req_adr[15:14]);
			ext.adr.rom.ofs  = req_adr[13:0];
			ext.cs_cart      = req;
			if (emu_mbc && req_region.rom) begin
				ext.adr.rom.bank = req_adr[14] ? rom_bank : '0;
				ext.cs_crom      = req;
			end else if (emu_mbc) begin
				ext.adr.ram.pad  = '0;
				ext.adr.ram.bank = ram_bank;
				ext.adr.ram.ofs  = req_adr[12:0];
				ext.cs_cram      = req & ram_en;
				ext.cs_cart      = req & ram_en;   // disabled ram is open bus.
			end
		end

		ext.rd = req_rd & (ext.cs_ram | ext.cs_cart);
		ext.wr = req_wr & (ext.cs_ram | ext.cs_cart) & ~mbc_wr;
	end

endmodule

`default_nettype wire

//--- hdl/gb_addr_decode.sv
`default_nettype none

module gb_addr_decode (
	input  wire [gb_bus_pkg::adr_w-1:0] adr,
	output gb_bus_pkg::region_t         region
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// memory map, ascending
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		region = '0;

		if (adr < gb_bus_pkg::vram_base) begin
			region.rom = 1'b1;
		end else if (adr < gb_bus_pkg::cram_base) begin
			region.vram = 1'b1;
		end else if (adr < gb_bus_pkg::wram_base) begin
			region.cram = 1'b1;
		end else if (adr <= gb_bus_pkg::echo_end) begin
			region.wram = 1'b1;   // echo lands here too.
		end else if (adr >= gb_bus_pkg::oam_base && adr <= gb_bus_pkg::oam_end) begin
			region.oam = 1'b1;
		end else if (adr >= gb_bus_pkg::io_base && adr < gb_bus_pkg::hram_base) begin
			// only the dma start register is left in the io page.
			region.io_dma = (adr == gb_bus_pkg::dma_reg_adr);
		end else if (adr >= gb_bus_pkg::hram_base) begin
			region.hram = (adr != '1);   // ffff is not ram.
		end
	end

endmodule

`default_nettype wire

//--- hdl/gb_bus_pkg.sv
`default_nettype none

package gb_bus_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// widths and cpu memory map
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int adr_w     = 16;
	localparam int data_w    = 8;
	localparam int ext_adr_w = 21;

	localparam logic [adr_w-1:0] vram_base   = 16'h8000;
	localparam logic [adr_w-1:0] cram_base   = 16'hA000;
	localparam logic [adr_w-1:0] wram_base   = 16'hC000;
	localparam logic [adr_w-1:0] echo_end    = 16'hFDFF;
	localparam logic [adr_w-1:0] oam_base    = 16'hFE00;
	localparam logic [adr_w-1:0] oam_end     = 16'hFE9F;
	localparam logic [adr_w-1:0] io_base     = 16'hFF00;
	localparam logic [adr_w-1:0] hram_base   = 16'hFF80;
	localparam logic [adr_w-1:0] dma_reg_adr = 16'hFF46;

	localparam int                oam_bytes = 160;
	localparam logic [data_w-1:0] open_bus  = 8'hFF;

	// on-chip ram sizes follow from the map.
	localparam int vram_depth = int'(cram_base - vram_base);
	localparam int oam_depth  = int'(io_base - oam_base);
	localparam int hram_depth = (1 << adr_w) - int'(hram_base);
	localparam int vram_aw    = $clog2(vram_depth);
	localparam int oam_aw     = $clog2(oam_depth);
	localparam int hram_aw    = $clog2(hram_depth);

	// cartridge banking.
	localparam int rom_bank_bits = 7;
	localparam int ram_bank_bits = 2;
	localparam int rom_bank_size = 16384;
	localparam int ram_bank_size = 8192;
	localparam int rom_ofs_w     = $clog2(rom_bank_size);
	localparam int ram_ofs_w     = $clog2(ram_bank_size);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// bus types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef struct packed {
		logic rom;
		logic vram;
		logic cram;
		logic wram;   // includes echo.
		logic oam;
		logic io_dma;
		logic hram;
	} region_t;

	typedef struct packed {
		logic [rom_bank_bits-1:0] bank;
		logic [rom_ofs_w-1:0]     ofs;
	} rom_view_t;

	typedef struct packed {
		logic [ext_adr_w-ram_bank_bits-ram_ofs_w-1:0] pad;
		logic [ram_bank_bits-1:0]                     bank;
		logic [ram_ofs_w-1:0]                         ofs;
	} ram_view_t;

	// same 21 address bits, seen as rom bank/offset or ram bank/offset.
	typedef union packed {
		rom_view_t rom;
		ram_view_t ram;
	} ext_adr_u;

	typedef struct packed {
		ext_adr_u          adr;
		logic [data_w-1:0] wdata;
		logic              rd;
		logic              wr;
		logic              cs_ram;
		logic              cs_cart;
		logic              cs_crom;
		logic              cs_cram;
	} ext_bus_t;

endpackage

`default_nettype wire

//--- hdl/gb_bus_top.sv
`default_nettype none

module gb_bus_top (
	input  wire                           gbclk,
	input  wire                           arst_n,
	input  wire  [gb_bus_pkg::adr_w-1:0]  paddr,
	input  wire                           psel,
	input  wire                           penable,
	input  wire                           pwrite,
	input  wire  [gb_bus_pkg::data_w-1:0] pwdata,
	output logic [gb_bus_pkg::data_w-1:0] prdata,
	output logic                          pready,
	input  wire                           emu_mbc,
	output gb_bus_pkg::ext_bus_t          ext,
	input  wire  [gb_bus_pkg::data_w-1:0] ext_rdata
);

	gb_bus_pkg::region_t cpu_region;
	gb_bus_pkg::region_t dma_region;
	gb_bus_pkg::region_t ext_req_region;

	logic                           dma_active;
	logic                           dma_src_rd;
	logic                           dma_oam_wr;
	logic                           dma_reg_wr;
	logic [gb_bus_pkg::adr_w-1:0]   dma_src_adr;
	logic [gb_bus_pkg::oam_aw-1:0]  dma_oam_idx;
	logic [gb_bus_pkg::data_w-1:0]  dma_oam_wdata;
	logic [gb_bus_pkg::data_w-1:0]  dma_reg_q;
	logic [gb_bus_pkg::data_w-1:0]  dma_src_rdata;

	logic [gb_bus_pkg::adr_w-1:0]   ext_req_adr;
	logic                           ext_req_rd;
	logic                           ext_req_wr;
	logic [gb_bus_pkg::data_w-1:0]  ext_req_wdata;

	logic [gb_bus_pkg::vram_aw-1:0] vram_adr;
	logic [gb_bus_pkg::data_w-1:0]  vram_wdata;
	logic [gb_bus_pkg::data_w-1:0]  vram_rdata;
	logic                           vram_we;
	logic [gb_bus_pkg::oam_aw-1:0]  oam_adr;
	logic [gb_bus_pkg::data_w-1:0]  oam_wdata;
	logic [gb_bus_pkg::data_w-1:0]  oam_rdata;
	logic                           oam_we;
	logic [gb_bus_pkg::hram_aw-1:0] hram_adr;
	logic [gb_bus_pkg::data_w-1:0]  hram_wdata;
	logic [gb_bus_pkg::data_w-1:0]  hram_rdata;
	logic                           hram_we;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// decode, arbitration, dma, mapper
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	gb_addr_decode u_cpu_dec (.adr(paddr), .region(cpu_region));

	gb_addr_decode u_dma_dec (.adr(dma_src_adr), .region(dma_region));   // dma source.

	bus_arbiter u_arb (
		.gbclk(gbclk), .arst_n(arst_n),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
		.prdata(prdata), .pready(pready),
		.cpu_region(cpu_region), .dma_region(dma_region),
		.dma_active(dma_active), .dma_src_adr(dma_src_adr), .dma_src_rd(dma_src_rd),
		.dma_oam_idx(dma_oam_idx), .dma_oam_wr(dma_oam_wr), .dma_oam_wdata(dma_oam_wdata),
		.dma_reg_q(dma_reg_q), .dma_reg_wr(dma_reg_wr), .dma_src_rdata(dma_src_rdata),
		.vram_adr(vram_adr), .vram_wdata(vram_wdata), .vram_we(vram_we),
		.vram_rdata(vram_rdata),
		.oam_adr(oam_adr), .oam_wdata(oam_wdata), .oam_we(oam_we), .oam_rdata(oam_rdata),
		.hram_adr(hram_adr), .hram_wdata(hram_wdata), .hram_we(hram_we),
		.hram_rdata(hram_rdata),
		.ext_req_adr(ext_req_adr), .ext_req_rd(ext_req_rd), .ext_req_wr(ext_req_wr),
		.ext_req_wdata(ext_req_wdata), .ext_req_region(ext_req_region),
		.ext_rdata(ext_rdata)
	);

	oam_dma u_dma (
		.gbclk(gbclk), .arst_n(arst_n),
		.reg_wr(dma_reg_wr), .reg_wdata(pwdata), .reg_q(dma_reg_q),
		.active(dma_active), .src_adr(dma_src_adr), .src_rd(dma_src_rd),
		.src_rdata(dma_src_rdata),
		.oam_idx(dma_oam_idx), .oam_wr(dma_oam_wr), .oam_wdata(dma_oam_wdata)
	);

	cart_mapper u_mbc (
		.gbclk(gbclk), .arst_n(arst_n), .emu_mbc(emu_mbc),
		.req_adr(ext_req_adr), .req_rd(ext_req_rd), .req_wr(ext_req_wr),
		.req_wdata(ext_req_wdata), .req_region(ext_req_region),
		.ext(ext)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// on-chip rams
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	gb_ram #(.depth(gb_bus_pkg::vram_depth)) u_vram (
		.gbclk(gbclk), .adr(vram_adr), .wdata(vram_wdata), .we(vram_we), .rdata(vram_rdata)
	);

	gb_ram #(.depth(gb_bus_pkg::oam_depth)) u_oam (
		.gbclk(gbclk), .adr(oam_adr), .wdata(oam_wdata), .we(oam_we), .rdata(oam_rdata)
	);

	gb_ram #(.depth(gb_bus_pkg::hram_depth)) u_hram (
		.gbclk(gbclk), .adr(hram_adr), .wdata(hram_wdata), .we(hram_we), .rdata(hram_rdata)
	);

endmodule

`default_nettype wire

//--- hdl/gb_ram.sv
`default_nettype none

module gb_ram #(
	parameter int depth = 256
) (
	input  wire                           gbclk,
	input  wire [$clog2(depth)-1:0]       adr,
	input  wire [gb_bus_pkg::data_w-1:0]  wdata,
	input  wire                           we,
	output logic [gb_bus_pkg::data_w-1:0] rdata
);

	logic [gb_bus_pkg::data_w-1:0] mem [depth];

	always_ff @(posedge gbclk) begin
		if (we) begin
			mem[adr] <= wdata;
		end
		rdata <= mem[adr];   // read-before-write.
	end

endmodule

`default_nettype wire

//--- hdl/oam_dma.sv
`default_nettype none

module oam_dma (
	input  wire                            gbclk,
	input  wire                            arst_n,
	input  wire                            reg_wr,
	input  wire  [gb_bus_pkg::data_w-1:0]  reg_wdata,
	output logic [gb_bus_pkg::data_w-1:0]  reg_q,
	output logic                           active,
	output logic [gb_bus_pkg::adr_w-1:0]   src_adr,
	output logic                           src_rd,
	input  wire  [gb_bus_pkg::data_w-1:0]  src_rdata,
	output logic [gb_bus_pkg::oam_aw-1:0]  oam_idx,
	output logic                           oam_wr,
	output logic [gb_bus_pkg::data_w-1:0]  oam_wdata
);

	// runs 0..oam_bytes, one extra step to drain the last write.
	logic [gb_bus_pkg::oam_aw-1:0] cnt;

	always_ff @(posedge gbclk or negedge arst_n) begin
		if (!arst_n) begin
			reg_q  <= '0;
			active <= 1'b0;
			cnt    <= '0;
		end else if (reg_wr) begin
			reg_q  <= reg_wdata;   // source page.
			active <= 1'b1;
			cnt    <= '0;
		end else if (active) begin
			cnt <= cnt + 1'b1;
			if (cnt == gb_bus_pkg::oam_aw'(gb_bus_pkg::oam_bytes)) begin
				active <= 1'b0;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// read stage at cnt, write stage at cnt-1
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign src_adr = {reg_q, cnt};
	assign src_rd  = active && (cnt < gb_bus_pkg::oam_bytes);

	// source data comes back one cycle after its read.
	assign oam_wr    = active && (cnt != '0);
	assign oam_idx   = cnt - 1'b1;
	assign oam_wdata = src_rdata;

endmodule

`default_nettype wire

//--- project.f
hdl/gb_bus_pkg.sv
hdl/gb_addr_decode.sv
hdl/gb_ram.sv
hdl/oam_dma.sv
hdl/cart_mapper.sv
hdl/bus_arbiter.sv
hdl/gb_bus_top.sv
tests/tb_ext_mem.sv
tests/tb_gb_bus.sv

//--- run.sh
#!/usr/bin/env bash
# builds the bus fabric testbench with verilator and runs it.
cd "$(dirname "$0")" || exit 1

log=sim.log
rm -f "$log"

verilator --binary --timing --assert -Wno-fatal --top-module tb_gb_bus \
	-f project.f -Mdir obj_dir \
	&& ./obj_dir/Vtb_gb_bus > "$log" 2>&1 \
	|| { echo "compile or simulation run did not complete"; cat "$log" 2>/dev/null; exit 1; }

cat "$log"

grep -q "Finished with errors" "$log" \
	&& { echo "simulation FAILED"; exit 1; } \
	|| { echo "simulation passed"; exit 0; }

//--- tests/tb_ext_mem.sv
`default_nettype none

module tb_ext_mem (
	input  wire                           gbclk,
	input  wire gb_bus_pkg::ext_bus_t     ext,
	output logic [gb_bus_pkg::data_w-1:0] rdata
);

	timeunit 1ns;
	timeprecision 1ps;

	logic [gb_bus_pkg::data_w-1:0] rom  [1 << gb_bus_pkg::ext_adr_w];
	logic [gb_bus_pkg::data_w-1:0] cram [(1 << gb_bus_pkg::ram_bank_bits) * gb_bus_pkg::ram_bank_size];
	logic [gb_bus_pkg::data_w-1:0] wram [8192];   // one 8 K work ram chip.

	int                   seed;
	int                   wr_cnt = 0;   // write log, count and last entry.
	gb_bus_pkg::ext_bus_t last_wr;

	initial begin
		seed = 6081;
		foreach (rom[i]) rom[i] = 8'($random(seed));
		foreach (cram[i]) cram[i] = 8'($random(seed));
		foreach (wram[i]) wram[i] = 8'($random(seed));
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// chips decoded through the rom and ram views
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		if (ext.cs_cram) begin
			rdata = cram[{ext.adr.ram.bank, ext.adr.ram.ofs}];
		end else if (ext.cs_cart) begin
			rdata = rom[{ext.adr.rom.bank, ext.adr.rom.ofs}];   // flat when the mapper is off.
		end else if (ext.cs_ram) begin
			rdata = wram[ext.adr.rom.ofs[12:0]];
		end else begin
			rdata = gb_bus_pkg::open_bus;
		end
	end

	always @(posedge gbclk) begin
		if (ext.wr) begin
			if (ext.cs_cram) begin
				cram[{ext.adr.ram.bank, ext.adr.ram.ofs}] <= ext.wdata;
			end else if (ext.cs_cart) begin
				rom[{ext.adr.rom.bank, ext.adr.rom.ofs}] <= ext.wdata;
			end else if (ext.cs_ram) begin
				wram[ext.adr.rom.ofs[12:0]] <= ext.wdata;
			end
			wr_cnt  <= wr_cnt + 1;
			last_wr <= ext;
		end
	end

endmodule

`default_nettype wire

//--- tests/tb_gb_bus.sv
`default_nettype none

module tb_gb_bus;

	timeunit 1ns;
	timeprecision 1ps;

	typedef enum logic [1:0] {op_wr, op_rd, op_rdm, op_rds} op_e;   // rdm, rds read the model.
	typedef enum logic [1:0] {ar_none, ar_rom, ar_cram, ar_wram} area_e;

	typedef struct packed {
		op_e         op;
		logic [15:0] adr;
		logic [7:0]  data;
		logic        mbc;
		area_e       area;
		logic [20:0] exp;   // byte, or external address.
	} row_t;

	logic                 gbclk;
	logic                 arst_n;
	logic [15:0]          paddr;
	logic                 psel;
	logic                 penable;
	logic                 pwrite;
	logic [7:0]           pwdata;
	logic [7:0]           prdata;
	logic                 pready;
	logic                 emu_mbc;
	gb_bus_pkg::ext_bus_t ext;
	logic [7:0]           ext_rdata;

	row_t  tbl[$];
	string names[$];
	int    errors = 0;
	int    tests = 0;
	int    cycles = 0;
	int    limit = 0;
	logic  test_bad;

	gb_bus_top DUT (
		.gbclk(gbclk), .arst_n(arst_n), .paddr(paddr), .psel(psel), .penable(penable),
		.pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.emu_mbc(emu_mbc), .ext(ext), .ext_rdata(ext_rdata)
	);

	tb_ext_mem ext_mem (.gbclk(gbclk), .ext(ext), .rdata(ext_rdata));

	initial begin
		gbclk = 1'b0;
		forever #10 gbclk = ~gbclk;
	end

	initial begin
		while (limit == 0 || cycles < limit) begin
			@(posedge gbclk);
			cycles++;
		end
		$display("timeout: the run did not finish within %0d cycles", limit);
		$display("Finished with errors");
		$finish;
	end

	// cartridge chip selects belong to the mapper alone.
	always @(posedge gbclk) begin
		if (!emu_mbc) begin
			assert (!(ext.cs_crom || ext.cs_cram)) else begin
				$display("cartridge rom or ram chip select asserted with the mapper off");
				errors++;
				test_bad = 1'b1;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// apb master and checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic apb_xfer(input logic wr, input logic [15:0] adr, input logic [7:0] wdata,
			input logic mbc, output logic [7:0] rdata, output int waits,
			output gb_bus_pkg::ext_bus_t bus);
		@(negedge gbclk);
		paddr   = adr;
		pwrite  = wr;
		pwdata  = wdata;
		emu_mbc = mbc;
		psel    = 1'b1;
		penable = 1'b0;
		@(negedge gbclk);
		penable = 1'b1;
		waits   = 0;
		do begin
			@(negedge gbclk);
			waits++;   // first access cycle is the wait state.
		end while (!pready);
		rdata = prdata;
		bus   = ext;
		@(negedge gbclk);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] got);
		assert (got === exp) else begin
			$display("[ERROR] %s: expected %h, got %h", name, exp, got);
			errors++;
			test_bad = 1'b1;
		end
	endtask

	task automatic check_write(input string name, input area_e area, input logic [20:0] exp,
			input int n_before);
		int   n_exp;
		logic cs_ok;
		n_exp = (area == ar_none) ? n_before : n_before + 1;
		case (area)
			ar_wram: cs_ok = ext_mem.last_wr.cs_ram;
			ar_cram: cs_ok = ext_mem.last_wr.cs_cram;
			default: cs_ok = ext_mem.last_wr.cs_cart && !ext_mem.last_wr.cs_cram;
		endcase
		assert (ext_mem.wr_cnt == n_exp) else begin
			$display("[ERROR] %s: expected %0d external writes, got %0d", name, n_exp,
					ext_mem.wr_cnt);
			errors++;
			test_bad = 1'b1;
		end
		if (area != ar_none && !test_bad) begin
			assert (cs_ok) else begin
				$display("[ERROR] %s: expected chip %s, got cs_ram %b cs_cart %b cs_cram %b",
						name, area.name(), ext_mem.last_wr.cs_ram,
						ext_mem.last_wr.cs_cart, ext_mem.last_wr.cs_cram);
				errors++;
				test_bad = 1'b1;
			end
			assert (ext_mem.last_wr.adr == exp) else begin
				$display("[ERROR] %s: expected address %h, got %h", name, exp,
						ext_mem.last_wr.adr);
				errors++;
				test_bad = 1'b1;
			end
		end
	endtask

	// strobe and selects of a cartridge read as seen on the bus.
	task automatic compare_cart_selects(input string name, input area_e area, input logic mbc,
			input gb_bus_pkg::ext_bus_t bus);
		logic [3:0] exp;
		logic [3:0] got;
		exp = (area == ar_cram) ? 4'b1101 : {2'b11, mbc, 1'b0};   // rd, cart, crom, cram.
		got = {bus.rd, bus.cs_cart, bus.cs_crom, bus.cs_cram};
		assert (got === exp) else begin
			$display("[ERROR] %s: expected rd and chip selects %b, got %b", name, exp, got);
			errors++;
			test_bad = 1'b1;
		end
	endtask

	function automatic logic [7:0] model_byte(input area_e area, input logic [20:0] adr);
		case (area)
			ar_rom:  return ext_mem.rom[adr];
			ar_cram: return ext_mem.cram[adr[14:0]];
			ar_wram: return ext_mem.wram[adr[12:0]];
			default: return gb_bus_pkg::open_bus;
		endcase
	endfunction

	task automatic add_row(input op_e op, input logic [15:0] adr, input logic [7:0] data,
			input logic mbc, input area_e area, input logic [20:0] exp, input string name);
		tbl.push_back(row_t'{op, adr, data, mbc, area, exp});
		names.push_back(name);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus table
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic build_table();
		add_row(op_wr,  16'hFF80, 8'h5A, 1'b0, ar_none, 21'h0,      "hram write low");
		add_row(op_rd,  16'hFF80, 8'h00, 1'b0, ar_none, 21'h5A,     "hram read low");
		add_row(op_wr,  16'hFFFE, 8'hA5, 1'b0, ar_none, 21'h0,      "hram write high");
		add_row(op_rd,  16'hFFFE, 8'h00, 1'b0, ar_none, 21'hA5,     "hram read high");
		add_row(op_wr,  16'h8000, 8'h3C, 1'b0, ar_none, 21'h0,      "vram write first");
		add_row(op_rd,  16'h8000, 8'h00, 1'b0, ar_none, 21'h3C,     "vram read first");
		add_row(op_wr,  16'h9FFF, 8'hC3, 1'b0, ar_none, 21'h0,      "vram write last");
		add_row(op_rd,  16'h9FFF, 8'h00, 1'b0, ar_none, 21'hC3,     "vram read last");
		add_row(op_wr,  16'hFE00, 8'h11, 1'b0, ar_none, 21'h0,      "oam write first");
		add_row(op_rd,  16'hFE00, 8'h00, 1'b0, ar_none, 21'h11,     "oam read first");
		add_row(op_wr,  16'hFE9F, 8'h22, 1'b0, ar_none, 21'h0,      "oam write last");
		add_row(op_rd,  16'hFE9F, 8'h00, 1'b0, ar_none, 21'h22,     "oam read last");
		add_row(op_rd,  16'hFEA0, 8'h00, 1'b0, ar_none, 21'hFF,     "unused area start");
		add_row(op_rd,  16'hFEFF, 8'h00, 1'b0, ar_none, 21'hFF,     "unused area end");
		add_row(op_rd,  16'hFF00, 8'h00, 1'b0, ar_none, 21'hFF,     "io page start");
		add_row(op_rd,  16'hFF47, 8'h00, 1'b0, ar_none, 21'hFF,     "io next to dma");
		add_row(op_rd,  16'hFF46, 8'h00, 1'b0, ar_none, 21'h00,     "dma register after reset");
		add_row(op_wr,  16'hFFFF, 8'h00, 1'b0, ar_none, 21'h0,      "ffff write");
		add_row(op_rd,  16'hFFFF, 8'h00, 1'b0, ar_none, 21'hFF,     "ffff read");
		// work ram and its echo.
		add_row(op_wr,  16'hC010, 8'h77, 1'b0, ar_wram, 21'hC010,   "wram write");
		add_row(op_rd,  16'hC010, 8'h00, 1'b0, ar_none, 21'h77,     "wram read");
		add_row(op_rd,  16'hE010, 8'h00, 1'b0, ar_none, 21'h77,     "echo read");
		add_row(op_wr,  16'hF234, 8'h88, 1'b1, ar_wram, 21'hD234,   "echo write");
		add_row(op_rd,  16'hD234, 8'h00, 1'b1, ar_none, 21'h88,     "wram read of echo write");
		// rom banking with the mapper on.
		add_row(op_rdm, 16'h4000, 8'h00, 1'b1, ar_rom,  21'h04000,  "rom bank 1 after reset");
		add_row(op_rdm, 16'h0123, 8'h00, 1'b1, ar_rom,  21'h00123,  "rom bank 0 area");
		add_row(op_wr,  16'h2000, 8'h05, 1'b1, ar_none, 21'h0,      "select rom bank 5");
		add_row(op_rdm, 16'h4000, 8'h00, 1'b1, ar_rom,  21'h14000,  "rom bank 5 start");
		add_row(op_rdm, 16'h7FFF, 8'h00, 1'b1, ar_rom,  21'h17FFF,  "rom bank 5 end");
		add_row(op_wr,  16'h2000, 8'h00, 1'b1, ar_none, 21'h0,      "select rom bank 0");
		add_row(op_rdm, 16'h4010, 8'h00, 1'b1, ar_rom,  21'h04010,  "rom bank 0 gives 1");
		add_row(op_wr,  16'h3FFF, 8'h7F, 1'b1, ar_none, 21'h0,      "select rom bank 127");
		add_row(op_rdm, 16'h5555, 8'h00, 1'b1, ar_rom,  21'h1FD555, "rom bank 127 read");
		// cartridge ram.
		add_row(op_rd,  16'hA000, 8'h00, 1'b1, ar_none, 21'hFF,     "cart ram disabled");
		add_row(op_wr,  16'hA000, 8'h12, 1'b1, ar_none, 21'h0,      "cart ram write ignored");
		add_row(op_rd,  16'hA000, 8'h00, 1'b1, ar_none, 21'hFF,     "cart ram still disabled");
		add_row(op_wr,  16'h0000, 8'h0A, 1'b1, ar_none, 21'h0,      "cart ram enable");
		add_row(op_wr,  16'h4000, 8'h02, 1'b1, ar_none, 21'h0,      "select ram bank 2");
		add_row(op_wr,  16'hA345, 8'h9C, 1'b1, ar_cram, 21'h04345,  "cart ram bank 2 write");
		add_row(op_rd,  16'hA345, 8'h00, 1'b1, ar_none, 21'h9C,     "cart ram bank 2 read");
		add_row(op_wr,  16'h5FFF, 8'h01, 1'b1, ar_none, 21'h0,      "select ram bank 1");
		add_row(op_rdm, 16'hA345, 8'h00, 1'b1, ar_cram, 21'h02345,  "cart ram bank 1 read");
		add_row(op_wr,  16'h1FFF, 8'h00, 1'b1, ar_none, 21'h0,      "cart ram disable");
		add_row(op_rd,  16'hA345, 8'h00, 1'b1, ar_none, 21'hFF,     "cart ram disabled again");
		// oam dma from page c1.
		add_row(op_wr,  16'hC150, 8'h6B, 1'b0, ar_wram, 21'hC150,   "dma source byte");
		add_row(op_wr,  16'hFF46, 8'hC1, 1'b0, ar_none, 21'h0,      "dma start");
		add_row(op_rd,  16'hFF80, 8'h00, 1'b0, ar_none, 21'h5A,     "hram read during dma");
		add_row(op_rds, 16'hFE05, 8'h00, 1'b0, ar_wram, 21'hC105,   "oam read during dma");
		add_row(op_rdm, 16'hFE00, 8'h00, 1'b0, ar_wram, 21'hC100,   "oam copy first");
		add_row(op_rdm, 16'hFE9F, 8'h00, 1'b0, ar_wram, 21'hC19F,   "oam copy last");
		add_row(op_rd,  16'hFE50, 8'h00, 1'b0, ar_none, 21'h6B,     "oam copy of cpu byte");
		add_row(op_rd,  16'hFF46, 8'h00, 1'b0, ar_none, 21'hC1,     "dma register readback");
		// mapper off, flat cartridge space.
		add_row(op_wr,  16'h2000, 8'h5A, 1'b0, ar_rom,  21'h02000,  "flat rom write");
		add_row(op_rd,  16'h2000, 8'h00, 1'b0, ar_none, 21'h5A,     "flat rom readback");
		add_row(op_rdm, 16'h6789, 8'h00, 1'b0, ar_rom,  21'h06789,  "flat rom read");
		add_row(op_wr,  16'hA010, 8'h3E, 1'b0, ar_rom,  21'h0A010,  "flat cart ram write");
		add_row(op_rd,  16'hA010, 8'h00, 1'b0, ar_none, 21'h3E,     "flat cart ram read");
	endtask

	initial begin
		row_t                 r;
		logic [7:0]           rd;
		int                   waits;
		int                   n_wr;
		gb_bus_pkg::ext_bus_t bus;
		paddr   = '0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		pwdata  = '0;
		emu_mbc = 1'b0;
		arst_n  = 1'b0;
		build_table();
		limit = tbl.size() * 200 + 2000;
		repeat (4) @(negedge gbclk);
		arst_n = 1'b1;

		test_bad = 1'b0;
		tests++;
		check_value("reset state", 8'h00,
				{2'b00, pready, ext.rd, ext.wr, ext.cs_ram, ext.cs_cart, ext.cs_crom | ext.cs_cram});
		if (!test_bad) $display("[OK] reset state");

		for (int i = 0; i < tbl.size(); i++) begin
			r        = tbl[i];
			test_bad = 1'b0;
			n_wr     = ext_mem.wr_cnt;
			apb_xfer(r.op == op_wr, r.adr, r.data, r.mbc, rd, waits, bus);
			tests++;
			case (r.op)
				op_wr: check_write(names[i], r.area, r.exp, n_wr);
				op_rd: check_value(names[i], r.exp[7:0], rd);
				default: check_value(names[i], model_byte(r.area, r.exp), rd);
			endcase
			if (r.op == op_rdm && (r.area == ar_rom || r.area == ar_cram)) begin
				compare_cart_selects(names[i], r.area, r.mbc, bus);
			end
			if (r.op == op_rds) begin
				assert (waits > 1) else begin
					$display("[ERROR] %s: expected more than 1 wait state, got %0d",
							names[i], waits);
					errors++;
					test_bad = 1'b1;
				end
			end else begin
				assert (waits == 1) else begin
					$display("[ERROR] %s: expected 1 wait state, got %0d", names[i], waits);
					errors++;
					test_bad = 1'b1;
				end
			end
			if (!test_bad) $display("[OK] %s", names[i]);
		end

		$display("tests run: %0d, errors: %0d", tests, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire
